// File: design/cache_array.sv
`timescale 1ns/1ns

module cache_array (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    cache_port_if.array port
);
    import mem_stage_pkg::*;
    import mem_cache_pkg::*;

    logic [LINES-1:0]  valid;
    logic [TAG_W-1:0]  tag_mem  [LINES];
    logic [DATA_W-1:0] data_mem [LINES];

    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;

    // ***********************************************************
    // Address split
    // ***********************************************************

    assign index = port.lookup_addr[OFFSET_W +: INDEX_W];
    assign tag   = port.lookup_addr[ADDR_W-1 -: TAG_W];

    // ***********************************************************
    // Lookup
    // ***********************************************************

    assign port.hit     = valid[index] && (tag_mem[index] == tag);
    assign port.rd_word = data_mem[index];

    // ***********************************************************
    // Valid bits
    // ***********************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;                     // Wins over a fill
        end else if (port.fill_en) begin
            valid[index] <= 1'b1;
        end
    end

    // Tag and data written together on a fill
    always_ff @(posedge clk) begin
        if (port.fill_en) begin
            tag_mem[index]  <= tag;
            data_mem[index] <= port.fill_word;
        end
    end

endmodule

// File: design/cache_port_if.sv
`timescale 1ns/1ns

interface cache_port_if;
    import mem_stage_pkg::*;

    logic [ADDR_W-1:0] lookup_addr;
    logic              lookup_en;    // Valid load this cycle
    logic              hit;
    logic [DATA_W-1:0] rd_word;      // Word at the indexed line
    logic              fill_en;
    logic [DATA_W-1:0] fill_word;

    modport array (
        input  lookup_addr, fill_en, fill_word,
        output hit, rd_word
    );

    modport ctrl (
        input  lookup_en, lookup_addr, hit,
        output fill_en, fill_word
    );

    modport load (
        input  rd_word, lookup_addr
    );

endinterface

// File: design/fill_timer.sv
`timescale 1ns/1ns

module fill_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic done
);
    import mem_cache_pkg::*;

    logic [TIMER_W-1:0] count;

    // Loads on start, then counts down to zero and rests
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (start) begin
            count <= TIMER_W'(FILL_CYCLES);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Last cycle of the memory delay
    assign done = (count == TIMER_W'(1));

endmodule

// File: design/mem_cache_pkg.sv
package mem_cache_pkg;

    // ***********************************************************
    // Geometry
    // ***********************************************************

    localparam int LINES    = 16;  // One 64-bit word per line
    localparam int OFFSET_W = 3;   // Byte offset in the word
    localparam int INDEX_W  = 4;   // Address bits 6..3
    localparam int TAG_W    = 25;  // Address bits 31..7

    // ***********************************************************
    // Outside memory timing
    // ***********************************************************

    localparam int FILL_CYCLES = 6;  // Fixed answer delay
    localparam int TIMER_W     = 3;

    // Miss controller states
    typedef enum logic [1:0] {
        idle  = 2'd0,
        fill  = 2'd1,             // Waiting on memory
        write = 2'd2              // Fill word goes into the array
    } miss_state_e;

endpackage

// File: design/mem_stage.sv
`timescale 1ns/1ns

module mem_stage (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             valid_in,
    input  logic                             fwd_stall,
    input  logic                             mem_rd,
    input  logic                             flush,
    input  mem_stage_pkg::opsize_e           opsize_in,
    input  logic [3:0]                       size_ovr,
    input  logic [mem_stage_pkg::ADDR_W-1:0] mem_addr,
    input  logic [mem_stage_pkg::DATA_W-1:0] reg_val,
    input  logic [mem_stage_pkg::IMM_W-1:0]  imm,
    input  mem_stage_pkg::operand_src_e      op1_sel,
    input  mem_stage_pkg::operand_src_e      op2_sel,
    input  logic [mem_stage_pkg::DATA_W-1:0] fill_data,
    output logic                             fill_req,
    output logic [mem_stage_pkg::ADDR_W-1:0] fill_addr,
    output logic                             valid_out,
    output logic                             stall,
    output mem_stage_pkg::opsize_e           opsize_out,
    output logic [mem_stage_pkg::DATA_W-1:0] op1_val,
    output logic [mem_stage_pkg::DATA_W-1:0] op2_val
);

    cache_port_if cport ();

    logic cache_stall;
    logic timer_start;
    logic timer_done;

    // ***********************************************************
    // Lookup request
    // ***********************************************************

    assign cport.lookup_addr = mem_addr;
    assign cport.lookup_en   = valid_in && mem_rd;   // Only loads look up

    // ***********************************************************
    // Cache and miss handling
    // ***********************************************************

    cache_array cache_array_i (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .port  (cport.array)
    );

    miss_ctrl miss_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .port        (cport.ctrl),
        .fill_data   (fill_data),
        .timer_done  (timer_done),
        .timer_start (timer_start),
        .fill_req    (fill_req),
        .fill_addr   (fill_addr),
        .cache_stall (cache_stall)
    );

    fill_timer fill_timer_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (timer_start),
        .done  (timer_done)
    );

    // ***********************************************************
    // Operands
    // ***********************************************************

    operand_select operand_select_i (
        .opsize_in  (opsize_in),
        .size_ovr   (size_ovr),
        .port       (cport.load),
        .reg_val    (reg_val),
        .imm        (imm),
        .op1_sel    (op1_sel),
        .op2_sel    (op2_sel),
        .opsize_out (opsize_out),
        .op1_val    (op1_val),
        .op2_val    (op2_val)
    );

    // Either source holds the instruction here
    assign stall     = cache_stall || fwd_stall;
    assign valid_out = valid_in && !stall;

endmodule

// File: design/mem_stage_pkg.sv
package mem_stage_pkg;

    // ***********************************************************
    // Widths
    // ***********************************************************

    localparam int DATA_W = 64;   // Operand and memory word
    localparam int ADDR_W = 32;   // Load address
    localparam int IMM_W  = 48;   // Immediate before sign extension

    // ***********************************************************
    // Access size
    // ***********************************************************

    // Encoding follows the size override bit positions
    typedef enum logic [1:0] {
        size_byte  = 2'd0,        // 1 byte
        size_word  = 2'd1,        // 2 bytes
        size_dword = 2'd2,        // 4 bytes
        size_qword = 2'd3         // 8 bytes
    } opsize_e;

    // ***********************************************************
    // Operand source
    // ***********************************************************

    typedef enum logic [1:0] {
        src_reg  = 2'd0,          // Register value
        src_mem  = 2'd1,          // Sized load data
        src_imm  = 2'd2,          // Sign-extended immediate
        src_zero = 2'd3
    } operand_src_e;

endpackage

// File: design/miss_ctrl.sv
`timescale 1ns/1ns

module miss_ctrl (
    input  logic                             clk,
    input  logic                             rst_n,
    cache_port_if.ctrl                       port,
    input  logic [mem_stage_pkg::DATA_W-1:0] fill_data,
    input  logic                             timer_done,
    output logic                             timer_start,
    output logic                             fill_req,
    output logic [mem_stage_pkg::ADDR_W-1:0] fill_addr,
    output logic                             cache_stall
);
    import mem_stage_pkg::*;
    import mem_cache_pkg::*;

    miss_state_e state;
    miss_state_e state_next;
    logic        miss;

    assign miss = port.lookup_en && !port.hit;

    // ***********************************************************
    // State machine
    // ***********************************************************

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (miss) begin
                    state_next = fill;
                end
            end
            fill: begin
                if (timer_done) begin
                    state_next = write;
                end
            end
            write:   state_next = idle;      // Line is valid next cycle
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= idle;
            fill_req <= 1'b0;
        end else begin
            state    <= state_next;
            fill_req <= timer_start;         // One-cycle request pulse
        end
    end

    // Address of the missing word, held for the memory
    always_ff @(posedge clk) begin
        if (timer_start) begin
            fill_addr <= {port.lookup_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        end
    end

    assign timer_start = (state == idle) && miss;

    // ***********************************************************
    // Fill write and stall
    // ***********************************************************

    assign port.fill_en   = (state == write);
    assign port.fill_word = fill_data;

    // Miss is flagged in the cycle it is seen
    assign cache_stall = (state != idle) || miss;

endmodule

// File: design/operand_select.sv
`timescale 1ns/1ns

module operand_select (
    input  mem_stage_pkg::opsize_e           opsize_in,
    input  logic [3:0]                       size_ovr,
    cache_port_if.load                       port,
    input  logic [mem_stage_pkg::DATA_W-1:0] reg_val,
    input  logic [mem_stage_pkg::IMM_W-1:0]  imm,
    input  mem_stage_pkg::operand_src_e      op1_sel,
    input  mem_stage_pkg::operand_src_e      op2_sel,
    output mem_stage_pkg::opsize_e           opsize_out,
    output logic [mem_stage_pkg::DATA_W-1:0] op1_val,
    output logic [mem_stage_pkg::DATA_W-1:0] op2_val
);
    import mem_stage_pkg::*;

    opsize_e           size_use;
    logic [DATA_W-1:0] shifted;
    logic [DATA_W-1:0] load_data;
    logic [DATA_W-1:0] imm_ext;

    function automatic logic [DATA_W-1:0] pick_operand(
        input operand_src_e      sel,
        input logic [DATA_W-1:0] reg_v,
        input logic [DATA_W-1:0] mem_v,
        input logic [DATA_W-1:0] imm_v
    );
        case (sel)
            src_reg: return reg_v;
            src_mem: return mem_v;
            src_imm: return imm_v;
            default: return '0;
        endcase
    endfunction

    // ***********************************************************
    // Access size
    // ***********************************************************

    // Lowest override bit wins
    always_comb begin
        if (size_ovr == 4'b0000) begin
            size_use = opsize_in;
        end else if (size_ovr[0]) begin
            size_use = size_byte;
        end else if (size_ovr[1]) begin
            size_use = size_word;
        end else if (size_ovr[2]) begin
            size_use = size_dword;
        end else begin
            size_use = size_qword;
        end
    end

    assign opsize_out = size_use;

    // ***********************************************************
    // Load data
    // ***********************************************************

    assign shifted = port.rd_word >> {port.lookup_addr[2:0], 3'b000};

    always_comb begin
        case (size_use)
            size_byte:  load_data = {{(DATA_W-8){1'b0}}, shifted[7:0]};
            size_word:  load_data = {{(DATA_W-16){1'b0}}, shifted[15:0]};
            size_dword: load_data = {{(DATA_W-32){1'b0}}, shifted[31:0]};
            default:    load_data = shifted;
        endcase
    end

    assign imm_ext = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};  // Sign extend

    assign op1_val = pick_operand(op1_sel, reg_val, load_data, imm_ext);
    assign op2_val = pick_operand(op2_sel, reg_val, load_data, imm_ext);

endmodule

// File: mem_stage.f
design/mem_stage_pkg.sv
design/mem_cache_pkg.sv
design/cache_port_if.sv
design/fill_timer.sv
design/cache_array.sv
design/miss_ctrl.sv
design/operand_select.sv
design/mem_stage.sv
verification/mem_stage_assert.sv
verification/mem_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the mem_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f mem_stage.f \
    --top-module mem_stage_tb \
    --Mdir obj_dir -o mem_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/mem_stage_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

// File: verification/mem_stage_assert.sv
`timescale 1ns/1ns

module mem_stage_assert (
    input logic clk,
    input logic rst_n,
    input logic stall,
    input logic fill_req
);
    import mem_cache_pkg::*;

    // ***********************************************************
    // Stall
    // ***********************************************************

    // Stall holds until the fill word is written
    stall_through_fill: assert property (
        @(posedge clk) disable iff (!rst_n) $past(fill_req, FILL_CYCLES) |-> stall
    ) else $error("stall fell before the fill word was written");

    // ***********************************************************
    // Fill request
    // ***********************************************************

    single_fill_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) fill_req |=> !fill_req
    ) else $error("fill_req high for two cycles in a row");

    fill_needs_stall: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(fill_req) |-> stall
    ) else $error("fill_req rose without stall");

    // Checked during reset too
    no_fill_in_reset: assert property (
        @(posedge clk) !rst_n |-> !fill_req
    ) else $error("fill_req high during reset");

endmodule

bind mem_stage mem_stage_assert mem_stage_assert_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .fill_req (fill_req)
);

// File: verification/mem_stage_tb.sv
`timescale 1ns/1ns

module mem_stage_tb;
    import mem_stage_pkg::*;
    import mem_cache_pkg::*;

    localparam int CLK_NS      = 4;
    localparam int RESET_CYC   = 4;
    localparam int MISS_STALL  = FILL_CYCLES + 2;
    localparam int TEST_LOADS  = 300;                 // Bound on loads over all tests
    localparam int WATCHDOG_NS = (TEST_LOADS * (MISS_STALL + 1) + 200) * CLK_NS;
    localparam logic [DATA_W-1:0] MEM_SALT = 64'h5A3C_96E1_0F87_D24B;

    logic                 clk;
    logic                 rst_n;
    logic                 valid_in;
    logic                 fwd_stall;
    logic                 mem_rd;
    logic                 flush;
    opsize_e              opsize_in;
    logic [3:0]           size_ovr;
    logic [ADDR_W-1:0]    mem_addr;
    logic [DATA_W-1:0]    reg_val;
    logic [IMM_W-1:0]     imm;
    operand_src_e         op1_sel;
    operand_src_e         op2_sel;
    logic [DATA_W-1:0]    fill_data;
    logic                 fill_req;
    logic [ADDR_W-1:0]    fill_addr;
    logic                 valid_out;
    logic                 stall;
    opsize_e              opsize_out;
    logic [DATA_W-1:0]    op1_val;
    logic [DATA_W-1:0]    op2_val;

    int                   errors;
    int                   compares;
    int                   loads;
    int                   fill_count;
    logic [ADDR_W-1:0]    last_fill_addr;
    logic [DATA_W-1:0]    exp_op1;
    logic [DATA_W-1:0]    exp_op2;
    logic                 sb_valid [LINES];   // Scoreboard copy of the cache
    logic [TAG_W-1:0]     sb_tag   [LINES];

    mem_stage mem_stage_i (.*);

    // Outside memory answers with a fixed pattern of the address
    function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        return {addr, addr} ^ MEM_SALT;
    endfunction

    assign fill_data = mem_word(fill_addr);

    function automatic int ref_size(input opsize_e size, input logic [3:0] ovr);
        int b;
        if (ovr == 4'b0000) begin
            return int'(size);
        end
        for (b = 0; b < 4; b++) begin
            if (ovr[b]) begin
                return b;
            end
        end
        return 0;
    endfunction

    function automatic logic [DATA_W-1:0] ref_operand(
        input operand_src_e      sel,
        input logic [DATA_W-1:0] regv,
        input logic [IMM_W-1:0]  immv,
        input logic [ADDR_W-1:0] addr,
        input opsize_e           size,
        input logic [3:0]        ovr
    );
        logic [DATA_W-1:0] load;
        int                nbytes;
        load   = mem_word({addr[ADDR_W-1:3], 3'b000}) >> (int'(addr[2:0]) * 8);
        nbytes = 1 << ref_size(size, ovr);
        if (nbytes < 8) begin
            load = load & ((64'd1 << (8 * nbytes)) - 64'd1);
        end
        case (sel)
            src_reg: return regv;
            src_mem: return load;
            src_imm: return DATA_W'($signed(immv));
            default: return '0;
        endcase
    endfunction

    task automatic value_error(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        $display("Fail at %0t ns: %s got %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    // ***********************************************************
    // Clock, memory monitor and comparison
    // ***********************************************************

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n && fill_req) begin
            fill_count++;
            last_fill_addr = fill_addr;
        end
    end

    always @(posedge clk) begin
        if (rst_n && valid_out) begin
            exp_op1 = ref_operand(op1_sel, reg_val, imm, mem_addr, opsize_in, size_ovr);
            exp_op2 = ref_operand(op2_sel, reg_val, imm, mem_addr, opsize_in, size_ovr);
            compares++;
            if (op1_val !== exp_op1) value_error("op1_val", op1_val, exp_op1);
            if (op2_val !== exp_op2) value_error("op2_val", op2_val, exp_op2);
            if (int'(opsize_out) != ref_size(opsize_in, size_ovr)) begin
                value_error("opsize_out", DATA_W'(opsize_out),
                            DATA_W'(ref_size(opsize_in, size_ovr)));
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    // ***********************************************************
    // Stimulus tasks
    // ***********************************************************

    // Presents one load and holds it until valid_out
    task automatic issue_load(
        input logic [ADDR_W-1:0] addr,
        input opsize_e           size,
        input logic [3:0]        ovr,
        input operand_src_e      sel1,
        input operand_src_e      sel2,
        input logic [DATA_W-1:0] regv,
        input logic [IMM_W-1:0]  immv,
        input int                fwd_cycles,
        input bit                expect_miss
    );
        int stall_cyc;
        int fills_before;
        int exp_stall;
        bit accepted;
        exp_stall = expect_miss ? MISS_STALL : 0;
        if (fwd_cycles > exp_stall) exp_stall = fwd_cycles;
        @(negedge clk);
        valid_in  = 1'b1;
        mem_rd    = 1'b1;
        mem_addr  = addr;
        opsize_in = size;
        size_ovr  = ovr;
        op1_sel   = sel1;
        op2_sel   = sel2;
        reg_val   = regv;
        imm       = immv;
        fwd_stall = (fwd_cycles > 0);
        fills_before = fill_count;
        stall_cyc = 0;
        accepted  = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            if (stall !== (stall_cyc < exp_stall)) begin
                value_error("stall", DATA_W'(stall), DATA_W'(stall_cyc < exp_stall));
            end
            if (valid_out) begin
                accepted = 1'b1;
            end else begin
                stall_cyc++;
                @(negedge clk);
                fwd_stall = (stall_cyc < fwd_cycles);
            end
        end
        if (stall_cyc != exp_stall) begin
            value_error("stall cycles", DATA_W'(stall_cyc), DATA_W'(exp_stall));
        end
        if (fill_count - fills_before != (expect_miss ? 1 : 0)) begin
            value_error("fill_req count", DATA_W'(fill_count - fills_before),
                        DATA_W'(expect_miss ? 1 : 0));
        end
        if (expect_miss && last_fill_addr !== {addr[ADDR_W-1:3], 3'b000}) begin
            value_error("fill_addr", DATA_W'(last_fill_addr), DATA_W'({addr[ADDR_W-1:3], 3'b000}));
        end
        loads++;
    endtask

    task automatic flush_cache();
        @(negedge clk);
        valid_in = 1'b0;
        mem_rd   = 1'b0;
        flush    = 1'b1;
        @(negedge clk);
        flush    = 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        $display("Test %0d %s finished with %0d errors", num, name, errors - errors_before);
    endtask

    task automatic run_random_loads(input int count);
        int                i;
        logic [ADDR_W-1:0] addr;
        logic [3:0]        idx;
        bit                miss;
        int                fwd;
        for (i = 0; i < count; i++) begin
            addr = 32'h0004_0000 + ADDR_W'(($urandom % 64) * 8) + ADDR_W'($urandom % 8);
            idx  = addr[6:3];
            miss = !(sb_valid[idx] && sb_tag[idx] == addr[31:7]);
            fwd  = ($urandom % 4 == 0) ? 1 + int'($urandom % 3) : 0;
            issue_load(addr, opsize_e'(2'($urandom)), ($urandom % 2 == 0) ? 4'b0000 : 4'($urandom),
                       operand_src_e'(2'($urandom)), operand_src_e'(2'($urandom)),
                       {$urandom, $urandom}, IMM_W'({$urandom, $urandom}), fwd, miss);
            sb_valid[idx] = 1'b1;
            sb_tag[idx]   = addr[31:7];
        end
    endtask

    // ***********************************************************
    // Test sequence
    // ***********************************************************

    initial begin
        int                e0;
        int                s;
        int                off;
        int                k;
        logic [3:0]        ovrs [6];
        logic [ADDR_W-1:0] a_line;
        logic [ADDR_W-1:0] b_line;
        logic [ADDR_W-1:0] d_line;
        ovrs = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b1010, 4'b1100};
        a_line = 32'h0000_1234;
        b_line = 32'h0000_2000;
        d_line = 32'h0000_2080;   // Same index as b_line with another tag
        void'($urandom(30));
        errors     = 0;
        compares   = 0;
        loads      = 0;
        fill_count = 0;
        valid_in   = 1'b0;
        fwd_stall  = 1'b0;
        mem_rd     = 1'b0;
        flush      = 1'b0;
        opsize_in  = size_byte;
        size_ovr   = 4'b0000;
        mem_addr   = '0;
        reg_val    = '0;
        imm        = '0;
        op1_sel    = src_reg;
        op2_sel    = src_reg;
        rst_n = 1'b1;
        #1 rst_n = 1'b0;
        repeat (RESET_CYC) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        e0 = errors;
        issue_load(a_line, size_dword, 4'b0000, src_mem, src_reg, 64'h1111_2222_3333_4444,
                   48'h0, 0, 1'b1);
        issue_load(a_line + 32'd2, size_word, 4'b0000, src_mem, src_mem, 64'h0, 48'h0, 0, 1'b0);
        report_test(1, "cold miss then hit", e0);

        e0 = errors;
        issue_load(b_line, size_qword, 4'b0000, src_mem, src_zero, 64'h0, 48'h0, 0, 1'b1);
        for (s = 0; s < 4; s++) begin
            for (off = 0; off < 8; off++) begin
                issue_load(b_line + ADDR_W'(off), opsize_e'(s), 4'b0000, src_mem, src_zero,
                           64'h0, 48'h0, 0, 1'b0);
            end
        end
        // Override always names a size other than opsize_in
        for (k = 0; k < 6; k++) begin
            issue_load(b_line + ADDR_W'($urandom % 8), opsize_e'(2'(k + 2)), ovrs[k], src_zero,
                       src_mem, 64'h0, 48'h0, 0, 1'b0);
        end
        report_test(2, "size choice", e0);

        e0 = errors;
        issue_load(32'h0000_3010, size_dword, 4'b0000, src_reg, src_imm, 64'h0, 48'h0, 0, 1'b1);
        for (k = 0; k < 16; k++) begin
            issue_load(32'h0000_3011, size_dword, 4'b0000, operand_src_e'(2'(k / 4)),
                       operand_src_e'(2'(k % 4)), 64'hDEAD_BEEF_0BAD_F00D,
                       48'h8000_0000_1234, 0, 1'b0);
            if (k % 4 == 2 && op2_val !== 64'hFFFF_8000_0000_1234) begin
                value_error("op2_val", op2_val, 64'hFFFF_8000_0000_1234);
            end
        end
        report_test(3, "operand sources", e0);

        e0 = errors;
        issue_load(b_line + 32'd3, size_word, 4'b0000, src_mem, src_reg, 64'h77, 48'h0, 3, 1'b0);
        report_test(4, "forward stall", e0);

        e0 = errors;
        flush_cache();
        issue_load(b_line, size_qword, 4'b0000, src_mem, src_zero, 64'h0, 48'h0, 0, 1'b1);
        issue_load(d_line, size_qword, 4'b0000, src_mem, src_zero, 64'h0, 48'h0, 0, 1'b1);
        issue_load(b_line + 32'd4, size_dword, 4'b0000, src_mem, src_zero, 64'h0, 48'h0, 0, 1'b1);
        issue_load(d_line + 32'd1, size_byte, 4'b0000, src_mem, src_zero, 64'h0, 48'h0, 0, 1'b1);
        issue_load(d_line, size_qword, 4'b0000, src_mem, src_mem, 64'h0, 48'h0, 0, 1'b0);
        report_test(5, "flush and conflict", e0);

        e0 = errors;
        flush_cache();
        for (k = 0; k < LINES; k++) begin
            sb_valid[k] = 1'b0;
            sb_tag[k]   = '0;
        end
        run_random_loads(200);
        report_test(6, "random loads", e0);

        @(negedge clk);
        valid_in = 1'b0;
        mem_rd   = 1'b0;
        $display("Loads: %0d, operand compares: %0d, errors: %0d", loads, compares, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
